//--- source/wb_mem_pkg.sv
package wb_mem_pkg;

	// ****************************************
	// bus and burst sizes
	// ****************************************
	parameter int DATA_WIDTH = 128;
	parameter int SEL_WIDTH  = DATA_WIDTH / 8;
	// word address, same width as the memory interface bus
	parameter int ADR_WIDTH  = 31;
	parameter int MAX_BURST  = 16;

	// beat index and beat count widths
	parameter int BEAT_IDX_W = $clog2(MAX_BURST);
	parameter int CNT_W      = BEAT_IDX_W + 1;

	// cycle type and burst type codes
	parameter logic [2:0] CTI_INCR   = 3'b010;
	parameter logic [2:0] CTI_END    = 3'b111;
	parameter logic [1:0] BTE_LINEAR = 2'b00;

	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} op_t;

	// ****************************************
	// bus bundles
	// ****************************************
	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [ADR_WIDTH-1:0]  adr;
		logic [SEL_WIDTH-1:0]  sel;
		logic [DATA_WIDTH-1:0] dat;
		logic [2:0]            cti;
		logic [1:0]            bte;
	} wb_req_t;

	typedef struct packed {
		logic                  ack;
		logic                  err;
		logic [DATA_WIDTH-1:0] dat;
	} wb_rsp_t;

	// ****************************************
	// exerciser command and result
	// ****************************************
	typedef struct packed {
		op_t                   op;
		logic [ADR_WIDTH-1:0]  base;
		// burst length minus one
		logic [BEAT_IDX_W-1:0] len;
		logic [31:0]           seed;
	} mem_cmd_t;

	typedef struct packed {
		logic                  valid;
		logic [BEAT_IDX_W-1:0] index;
		logic [DATA_WIDTH-1:0] data;
	} beat_t;

	typedef struct packed {
		op_t              op;
		logic             bus_err;
		logic [CNT_W-1:0] beats;
		logic [CNT_W-1:0] mismatches;
	} run_status_t;

	// seed plus beat index, repeated across the word
	function automatic logic [DATA_WIDTH-1:0] pattern_word(
		input logic [31:0]           seed,
		input logic [BEAT_IDX_W-1:0] idx
	);
		logic [31:0] w;
		w = seed + 32'(idx);
		return {(DATA_WIDTH / 32){w}};
	endfunction

endpackage

//--- source/mem_store.sv
module mem_store
	import wb_mem_pkg::*;
#(
	parameter int MEM_ADDR_BITS = 6
)
(
	input  logic                     clk,
	input  logic                     we,
	input  logic [SEL_WIDTH-1:0]     sel,
	input  logic [MEM_ADDR_BITS-1:0] idx,
	input  logic [DATA_WIDTH-1:0]    wdata,
	output logic [DATA_WIDTH-1:0]    rdata
);

	localparam int DEPTH = 2 ** MEM_ADDR_BITS;

	logic [DATA_WIDTH-1:0] mem [DEPTH];

	// ****************************************
	// byte lane writes
	// ****************************************
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			for (int b = 0; b < SEL_WIDTH; b++)
			begin
				if (sel[b])
					mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
			end
		end
	end

	// registered read, old data on a same-cycle write
	always_ff @(posedge clk)
	begin
		rdata <= mem[idx];
	end

endmodule

//--- source/wb_mem_slave.sv
module wb_mem_slave
	import wb_mem_pkg::*;
#(
	parameter int MEM_ADDR_BITS = 6,
	parameter int WAIT_STATES   = 1
)
(
	input  logic                     clk,
	input  logic                     rst,
	input  wb_req_t                  req,
	output wb_rsp_t                  rsp,
	output logic                     mem_we,
	output logic [SEL_WIDTH-1:0]     mem_sel,
	output logic [MEM_ADDR_BITS-1:0] mem_idx,
	output logic [DATA_WIDTH-1:0]    mem_wdata,
	input  logic [DATA_WIDTH-1:0]    mem_rdata
);

	// counter needs at least one bit even with no wait states
	localparam int WCNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
	localparam logic [WCNT_W-1:0] WCNT_LAST = WCNT_W'(WAIT_STATES);

	logic [WCNT_W-1:0] wait_cnt;
	logic              active;
	logic              last_wait;
	logic              decide;
	logic              in_range;
	logic              ack_q;
	logic              err_q;

	assign active    = req.cyc && req.stb;
	assign last_wait = (wait_cnt == WCNT_LAST);

	// no new decision in the ack cycle, address there is still the old beat
	assign decide = active && last_wait && !ack_q && !err_q;

	// everything above the array index must be zero
	assign in_range = (req.adr[ADR_WIDTH-1:MEM_ADDR_BITS] == '0);

	// ****************************************
	// beat pacing
	// ****************************************
	// counting also runs through the ack cycle,
	// so beats come every WAIT_STATES+1 cycles
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wait_cnt <= '0;
			ack_q    <= 1'b0;
			err_q    <= 1'b0;
		end
		else
		begin
			ack_q <= decide && in_range;
			err_q <= decide && !in_range;
			if (!active || decide)
				wait_cnt <= '0;
			else if (!last_wait)
				wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// ****************************************
	// store access
	// ****************************************
	// write lands on the deciding edge, out of range never writes
	assign mem_we    = decide && in_range && req.we;
	assign mem_sel   = req.sel;
	assign mem_wdata = req.dat;

	// index is presented during the wait, read data
	// is registered on the same edge as ack
	assign mem_idx = req.adr[MEM_ADDR_BITS-1:0];

	always_comb
	begin
		rsp.ack = ack_q;
		rsp.err = err_q;
		rsp.dat = mem_rdata;
	end

endmodule

//--- source/wb_burst_master.sv
module wb_burst_master
	import wb_mem_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  mem_cmd_t         cmd,
	output wb_req_t          req,
	input  wb_rsp_t          rsp,
	output beat_t            beat,
	output logic             burst_end,
	output logic             burst_err,
	output logic [CNT_W-1:0] beat_count,
	output logic             busy,
	output mem_cmd_t         cur_cmd
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BURST,
		ST_FINISH
	} state_t;

	state_t                state;
	mem_cmd_t              cmd_q;
	logic [ADR_WIDTH-1:0]  adr_q;
	logic [CNT_W-1:0]      cnt_q;
	logic                  err_q;
	logic [BEAT_IDX_W-1:0] idx;
	logic                  last_beat;
	logic                  in_burst;
	logic                  is_write;

	assign in_burst  = (state == ST_BURST);
	assign idx       = cnt_q[BEAT_IDX_W-1:0];
	assign last_beat = (idx == cmd_q.len);
	assign is_write  = (cmd_q.op == OP_WRITE);

	// command register, loaded on an accepted start
	always_ff @(posedge clk)
	begin
		if (state == ST_IDLE && start)
			cmd_q <= cmd;
	end

	// ****************************************
	// burst sequencing
	// ****************************************
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			adr_q <= '0;
			cnt_q <= '0;
			err_q <= 1'b0;
		end
		else
		begin
			case (state)
				ST_IDLE:
				begin
					// start while busy never reaches here
					if (start)
					begin
						state <= ST_BURST;
						adr_q <= cmd.base;
						cnt_q <= '0;
						err_q <= 1'b0;
					end
				end
				ST_BURST:
				begin
					if (rsp.err)
					begin
						// err ends the burst, beat is not counted
						err_q <= 1'b1;
						state <= ST_FINISH;
					end
					else if (rsp.ack)
					begin
						adr_q <= adr_q + 1'b1;
						cnt_q <= cnt_q + 1'b1;
						if (last_beat)
							state <= ST_FINISH;
					end
				end
				ST_FINISH:
				begin
					state <= ST_IDLE;
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// ****************************************
	// bus request
	// ****************************************
	// fields only move on ack, so they hold through wait states
	always_comb
	begin
		req     = '0;
		req.cyc = in_burst;
		req.stb = in_burst;
		req.we  = in_burst && is_write;
		req.adr = adr_q;
		req.sel = '1;
		req.bte = BTE_LINEAR;
		req.cti = last_beat ? CTI_END : CTI_INCR;
		if (is_write)
			req.dat = pattern_word(cmd_q.seed, idx);
	end

	// read data goes straight to the checker
	always_comb
	begin
		beat.valid = in_burst && rsp.ack && !is_write;
		beat.index = idx;
		beat.data  = rsp.dat;
	end

	assign burst_end  = (state == ST_FINISH);
	assign burst_err  = err_q;
	assign beat_count = cnt_q;
	assign busy       = (state != ST_IDLE);
	assign cur_cmd    = cmd_q;

endmodule

//--- source/rd_checker.sv
module rd_checker
	import wb_mem_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  op_t              op,
	input  logic [31:0]      seed,
	input  beat_t            beat,
	input  logic             burst_end,
	input  logic             burst_err,
	input  logic [CNT_W-1:0] beat_count,
	output logic             done,
	output run_status_t      status
);

	logic [CNT_W-1:0]      mis_cnt;
	logic [DATA_WIDTH-1:0] expected;
	logic                  mismatch;

	// expected word for this beat
	assign expected = pattern_word(seed, beat.index);
	assign mismatch = beat.valid && (op == OP_READ) && (beat.data != expected);

	// ****************************************
	// mismatch count and status
	// ****************************************
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			mis_cnt <= '0;
			done    <= 1'b0;
			status  <= '0;
		end
		else
		begin
			done <= burst_end;
			// fresh count per accepted command
			if (start)
				mis_cnt <= '0;
			else if (mismatch)
				mis_cnt <= mis_cnt + 1'b1;
			// held until the next command finishes
			if (burst_end)
			begin
				status <= '{
					op:         op,
					bus_err:    burst_err,
					beats:      beat_count,
					mismatches: mis_cnt
				};
			end
		end
	end

endmodule

//--- source/wb_mem_subsys.sv
module wb_mem_subsys
	import wb_mem_pkg::*;
#(
	parameter int MEM_ADDR_BITS = 6,
	parameter int WAIT_STATES   = 1
)
(
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  mem_cmd_t    cmd,
	output logic        busy,
	output logic        done,
	output run_status_t status
);

	wb_req_t                  req;
	wb_rsp_t                  rsp;
	beat_t                    beat;
	mem_cmd_t                 cur_cmd;
	logic                     burst_end;
	logic                     burst_err;
	logic [CNT_W-1:0]         beat_count;
	logic                     start_ok;
	logic                     mem_we;
	logic [SEL_WIDTH-1:0]     mem_sel;
	logic [MEM_ADDR_BITS-1:0] mem_idx;
	logic [DATA_WIDTH-1:0]    mem_wdata;
	logic [DATA_WIDTH-1:0]    mem_rdata;

	// only a start the master takes may clear the checker
	assign start_ok = start && !busy;

	wb_burst_master u_master (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.cmd        (cmd),
		.req        (req),
		.rsp        (rsp),
		.beat       (beat),
		.burst_end  (burst_end),
		.burst_err  (burst_err),
		.beat_count (beat_count),
		.busy       (busy),
		.cur_cmd    (cur_cmd)
	);

	wb_mem_slave #(
		.MEM_ADDR_BITS (MEM_ADDR_BITS),
		.WAIT_STATES   (WAIT_STATES)
	) u_slave (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.rsp       (rsp),
		.mem_we    (mem_we),
		.mem_sel   (mem_sel),
		.mem_idx   (mem_idx),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

	mem_store #(
		.MEM_ADDR_BITS (MEM_ADDR_BITS)
	) u_store (
		.clk   (clk),
		.we    (mem_we),
		.sel   (mem_sel),
		.idx   (mem_idx),
		.wdata (mem_wdata),
		.rdata (mem_rdata)
	);

	// op and seed come from the master's latched command
	rd_checker u_checker (
		.clk        (clk),
		.rst        (rst),
		.start      (start_ok),
		.op         (cur_cmd.op),
		.seed       (cur_cmd.seed),
		.beat       (beat),
		.burst_end  (burst_end),
		.burst_err  (burst_err),
		.beat_count (beat_count),
		.done       (done),
		.status     (status)
	);

endmodule

//--- test/tb_clk_gen.sv
module tb_clk_gen #(
	parameter int PERIOD = 8
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
	end

	// free running, first rising edge at half a period
	always #(PERIOD / 2) clk = ~clk;

endmodule

//--- test/wb_mem_props.sv
module wb_mem_props
	import wb_mem_pkg::*;
(
	input logic    clk,
	input logic    rst,
	input wb_req_t req,
	input wb_rsp_t rsp
);

	// ****************************************
	// response rules
	// ****************************************
	ack_err_exclusive: assert property (
		@(posedge clk) disable iff (rst)
		!(rsp.ack && rsp.err)
	) else $error("ack and err high in the same cycle");

	ack_in_cycle: assert property (
		@(posedge clk) disable iff (rst)
		rsp.ack |-> (req.cyc && req.stb)
	) else $error("ack outside an active bus cycle");

	// ****************************************
	// request rules
	// ****************************************
	// a beat that is not answered must keep every field
	req_held_until_ack: assert property (
		@(posedge clk) disable iff (rst)
		(req.cyc && req.stb && !rsp.ack && !rsp.err) |=> $stable(req)
	) else $error("request changed before ack or err");

endmodule

bind wb_mem_slave wb_mem_props u_props (
	.clk (clk),
	.rst (rst),
	.req (req),
	.rsp (rsp)
);

//--- test/tb_wb_mem_subsys.sv
module tb_wb_mem_subsys
	import wb_mem_pkg::*;
();

	localparam int MEM_ADDR_BITS = 6;
	localparam int WAIT_STATES   = 1;
	localparam int MEM_DEPTH     = 2 ** MEM_ADDR_BITS;
	localparam int RESET_CYCLES  = 8;

	typedef struct packed {
		mem_cmd_t    cmd;
		run_status_t exp;
	} row_t;

	logic        clk;
	logic        rst;
	logic        start;
	mem_cmd_t    cmd;
	logic        busy;
	logic        done;
	run_status_t status;

	row_t                  rows[$];
	logic [DATA_WIDTH-1:0] ref_mem [MEM_DEPTH];
	integer                seed_var;
	int                    timeout_limit;
	int                    cycle_cnt;
	int                    done_count;

	tb_clk_gen #(
		.PERIOD (8)
	) u_clk_gen (
		.clk (clk)
	);

	wb_mem_subsys #(
		.MEM_ADDR_BITS (MEM_ADDR_BITS),
		.WAIT_STATES   (WAIT_STATES)
	) u_wb_mem_subsys (
		.clk    (clk),
		.rst    (rst),
		.start  (start),
		.cmd    (cmd),
		.busy   (busy),
		.done   (done),
		.status (status)
	);

	// ****************************************
	// compare tasks
	// ****************************************
	task automatic check_status(input string name, input run_status_t got, input run_status_t exp);
		string got_s;
		string exp_s;
		if (got !== exp)
		begin
			got_s = $sformatf("op=%0d err=%0b beats=%0d mis=%0d",
				got.op, got.bus_err, got.beats, got.mismatches);
			exp_s = $sformatf("op=%0d err=%0b beats=%0d mis=%0d",
				exp.op, exp.bus_err, exp.beats, exp.mismatches);
			$display("CHECK FAILED t=%0t %s got %s expected %s", $time, name, got_s, exp_s);
			$display("Simulation failed");
			$fatal(1, "status mismatch");
		end
	endtask

	task automatic check_logic(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED t=%0t %s got=%b expected=%b", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "level mismatch");
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("CHECK FAILED t=%0t %s got=%0d expected=%0d", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "count mismatch");
		end
	endtask

	// ****************************************
	// reference model
	// ****************************************
	// seed plus beat number in every 32-bit lane
	function automatic logic [DATA_WIDTH-1:0] expected_word(input logic [31:0] seed, input int n);
		logic [31:0] w;
		w = seed + n;
		return {(DATA_WIDTH / 32){w}};
	endfunction

	task automatic model_command(input mem_cmd_t c, output run_status_t s);
		logic [ADR_WIDTH-1:0]  a;
		logic [DATA_WIDTH-1:0] w;
		int                    i;
		s    = '0;
		s.op = c.op;
		for (i = 0; i <= int'(c.len); i++)
		begin
			a = c.base + ADR_WIDTH'(i);
			// first address past the array ends the burst
			if (a >= MEM_DEPTH)
			begin
				s.bus_err = 1'b1;
				break;
			end
			w = expected_word(c.seed, i);
			if (c.op == OP_WRITE)
				ref_mem[a[MEM_ADDR_BITS-1:0]] = w;
			else if (ref_mem[a[MEM_ADDR_BITS-1:0]] !== w)
				s.mismatches = s.mismatches + 1'b1;
			s.beats = s.beats + 1'b1;
		end
	endtask

	task automatic add_row(input op_t op, input int base, input int len, input logic [31:0] seed);
		row_t r;
		r.cmd.op   = op;
		r.cmd.base = ADR_WIDTH'(base);
		r.cmd.len  = BEAT_IDX_W'(len);
		r.cmd.seed = seed;
		model_command(r.cmd, r.exp);
		rows.push_back(r);
		timeout_limit += (len + 1) * (WAIT_STATES + 1) + 10;
	endtask

	// ****************************************
	// row sequence
	// ****************************************
	task automatic run_row(input int r);
		mem_cmd_t junk;
		junk      = rows[r].cmd;
		junk.op   = OP_WRITE;
		junk.base = '0;
		junk.len  = '1;
		junk.seed = ~rows[r].cmd.seed;
		@(posedge clk);
		#1;
		start = 1'b1;
		cmd   = rows[r].cmd;
		@(posedge clk);
		#1;
		check_logic("busy", busy, 1'b1);
		// second start lands while the burst runs
		start = 1'b1;
		cmd   = junk;
		@(posedge clk);
		#1;
		start = 1'b0;
		cmd   = '0;
		while (!done)
		begin
			@(posedge clk);
			#1;
		end
		check_status("status", status, rows[r].exp);
		check_logic("busy", busy, 1'b0);
		repeat (3) @(posedge clk);
		#1;
		check_count("done_count", done_count, r + 1);
	endtask

	always @(negedge clk)
	begin
		if (done)
			done_count++;
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_limit)
		begin
			$display("timeout: done never came within %0d cycles", timeout_limit);
			$display("Simulation failed");
			$fatal(1, "run stopped on timeout");
		end
	end

	initial
	begin
		logic [31:0] seed_a;
		logic [31:0] seed_b;
		logic [31:0] seed_c;
		rst           = 1'b1;
		start         = 1'b0;
		cmd           = '0;
		cycle_cnt     = 0;
		done_count    = 0;
		timeout_limit = RESET_CYCLES;
		seed_var      = 32'hdb9497b4;
		seed_a        = $random(seed_var);
		seed_b        = $random(seed_var);
		seed_c        = $random(seed_var);

		// write then read back, then read with the wrong seed
		add_row(OP_WRITE, 0, 7, seed_a);
		add_row(OP_READ, 0, 7, seed_a);
		add_row(OP_READ, 0, 7, seed_b);
		// single beat and full length bursts
		add_row(OP_WRITE, 8, 0, 32'hcafe_0001);
		add_row(OP_READ, 8, 0, 32'hcafe_0001);
		add_row(OP_WRITE, 16, 15, seed_c);
		add_row(OP_READ, 16, 15, seed_c);
		// overwrite two words inside the first block
		add_row(OP_WRITE, 2, 1, 32'h0000_5a5a);
		add_row(OP_READ, 0, 7, seed_a);
		// bursts running off the top of the array
		add_row(OP_WRITE, 60, 7, 32'h00c0_ffee);
		add_row(OP_READ, 60, 7, 32'h00c0_ffee);
		// the beat that got err must not wrap into the bottom words
		add_row(OP_READ, 0, 7, seed_a);

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		check_logic("busy", busy, 1'b0);
		check_logic("done", done, 1'b0);

		for (int r = 0; r < rows.size(); r++)
			run_row(r);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- tb.f
source/wb_mem_pkg.sv
source/mem_store.sv
source/wb_mem_slave.sv
source/wb_burst_master.sv
source/rd_checker.sv
source/wb_mem_subsys.sv
test/tb_clk_gen.sv
test/wb_mem_props.sv
test/tb_wb_mem_subsys.sv
